// ==== design/ahb_block_master.sv ====
`timescale 1ns/1ps

module ahb_block_master import decomp_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  logic [31:0] src_addr_i,
    input  logic [31:0] dst_addr_i,
    input  blk_cnt_t    len_i,
    input  logic        start_i,
    output logic        idle_o,

    output logic        hbusreq_o,
    input  logic        hgrant_i,
    output logic [31:0] haddr_o,
    output htrans_t     htrans_o,
    output logic        hwrite_o,
    output logic [31:0] hwdata_o,
    input  logic        hready_i,

    input  logic        decomp_done_i,
    output buf_addr_t   buf_addr_o,
    input  logic [63:0] decomp_rdata_i,

    output logic        beat_valid_o,
    output logic [3:0]  beat_idx_o
);

    // ------------------------------------------------------------------------
    // per block: one read burst, wait for decompressor, two write bursts
    //
    //   addr phase : | A0 | A1 | ... | A15 |
    //   data phase :      | D0 | ... | D14 | D15 |
    //   state      : 1ST  |     MIDDLE     | LAST|
    // ------------------------------------------------------------------------
    enum logic [3:0] {
        S_IDLE,
        S_RD_BUSREQ,
        S_RD_1ST_ADDR,
        S_RD_MIDDLE,
        S_RD_LAST_DATA,
        S_DECOMP,
        S_WR1_BUSREQ,
        S_WR1_1ST_ADDR,
        S_WR1_MIDDLE,
        S_WR1_LAST_DATA,
        S_WR2_BUSREQ,
        S_WR2_1ST_ADDR,
        S_WR2_MIDDLE,
        S_WR2_LAST_DATA
    } state, state_n;

    blk_cnt_t    blk_cnt, blk_cnt_n;
    beat_cnt_t   beat_cnt, beat_cnt_n;

    logic        hbusreq, hbusreq_n;
    logic [31:0] haddr, haddr_n;
    htrans_t     htrans, htrans_n;
    logic        hwrite, hwrite_n;
    logic [31:0] hwdata, hwdata_n;

    // command latched at start
    logic [31:0] src_q;
    logic [31:0] dst_q;
    blk_cnt_t    len_q;
    logic        cmd_load;

    logic        beat_en;
    logic        wr_accept;
    logic [31:0] wr_half;

    // even beat takes the low half of the entry, odd beat the high half
    assign wr_half = beat_cnt[0] ? decomp_rdata_i[63:32] : decomp_rdata_i[31:0];

    always_comb begin
        state_n    = state;
        blk_cnt_n  = blk_cnt;
        beat_cnt_n = beat_cnt;
        hbusreq_n  = hbusreq;
        haddr_n    = haddr;
        htrans_n   = htrans;
        hwrite_n   = hwrite;
        hwdata_n   = hwdata;
        cmd_load   = 1'b0;
        beat_en    = 1'b0;
        wr_accept  = 1'b0;

        case (state)
            S_IDLE: begin
                if (start_i && (len_i != '0)) begin
                    cmd_load  = 1'b1;
                    blk_cnt_n = '0;
                    hbusreq_n = 1'b1;
                    state_n   = S_RD_BUSREQ;
                end
            end
            S_RD_BUSREQ: begin
                if (hgrant_i) begin
                    hbusreq_n  = 1'b0;
                    haddr_n    = src_q + (32'(blk_cnt) << RD_BLK_SHIFT);
                    htrans_n   = HTRANS_NONSEQ;
                    hwrite_n   = 1'b0;
                    beat_cnt_n = '0;
                    state_n    = S_RD_1ST_ADDR;
                end
            end
            S_RD_1ST_ADDR: begin
                if (hready_i) begin
                    haddr_n  = haddr + WORD_BYTES;
                    htrans_n = HTRANS_SEQ;
                    state_n  = S_RD_MIDDLE;
                end
            end
            S_RD_MIDDLE: begin
                // beat_cnt counts data phases on reads
                if (hready_i) begin
                    beat_en    = 1'b1;
                    haddr_n    = haddr + WORD_BYTES;
                    beat_cnt_n = beat_cnt + 1'b1;
                    if (beat_cnt == beat_cnt_t'(BEATS_PER_BURST - 2)) begin
                        htrans_n = HTRANS_IDLE;
                        state_n  = S_RD_LAST_DATA;
                    end
                end
            end
            S_RD_LAST_DATA: begin
                if (hready_i) begin
                    beat_en    = 1'b1;
                    beat_cnt_n = beat_cnt + 1'b1;
                    state_n    = S_DECOMP;
                end
            end
            S_DECOMP: begin
                if (decomp_done_i) begin
                    hbusreq_n = 1'b1;
                    state_n   = S_WR1_BUSREQ;
                end
            end
            S_WR1_BUSREQ: begin
                if (hgrant_i) begin
                    hbusreq_n  = 1'b0;
                    haddr_n    = dst_q + (32'(blk_cnt) << WR_BLK_SHIFT);
                    htrans_n   = HTRANS_NONSEQ;
                    hwrite_n   = 1'b1;
                    beat_cnt_n = '0;
                    state_n    = S_WR1_1ST_ADDR;
                end
            end
            S_WR1_1ST_ADDR, S_WR2_1ST_ADDR: begin
                // beat_cnt counts address phases on writes
                if (hready_i) begin
                    wr_accept  = 1'b1;
                    haddr_n    = haddr + WORD_BYTES;
                    htrans_n   = HTRANS_SEQ;
                    beat_cnt_n = beat_cnt + 1'b1;
                    state_n    = (state == S_WR1_1ST_ADDR) ? S_WR1_MIDDLE : S_WR2_MIDDLE;
                end
            end
            S_WR1_MIDDLE: begin
                if (hready_i) begin
                    wr_accept  = 1'b1;
                    haddr_n    = haddr + WORD_BYTES;
                    beat_cnt_n = beat_cnt + 1'b1;
                    if (beat_cnt == beat_cnt_t'(BEATS_PER_BURST - 1)) begin
                        htrans_n = HTRANS_IDLE;
                        state_n  = S_WR1_LAST_DATA;
                    end
                end
            end
            S_WR1_LAST_DATA: begin
                if (hready_i) begin
                    hbusreq_n = 1'b1;
                    state_n   = S_WR2_BUSREQ;
                end
            end
            S_WR2_BUSREQ: begin
                // haddr already sits at the second half of the block
                if (hgrant_i) begin
                    hbusreq_n = 1'b0;
                    htrans_n  = HTRANS_NONSEQ;
                    state_n   = S_WR2_1ST_ADDR;
                end
            end
            S_WR2_MIDDLE: begin
                if (hready_i) begin
                    wr_accept  = 1'b1;
                    haddr_n    = haddr + WORD_BYTES;
                    beat_cnt_n = beat_cnt + 1'b1;
                    if (beat_cnt == beat_cnt_t'(2 * BEATS_PER_BURST - 1)) begin
                        htrans_n = HTRANS_IDLE;
                        state_n  = S_WR2_LAST_DATA;
                    end
                end
            end
            default: begin
                // S_WR2_LAST_DATA, block finished once the last word lands
                if (hready_i) begin
                    blk_cnt_n = blk_cnt + 1'b1;
                    if (blk_cnt_n == len_q) begin
                        hwrite_n = 1'b0;
                        state_n  = S_IDLE;
                    end else begin
                        hbusreq_n = 1'b1;
                        state_n   = S_RD_BUSREQ;
                    end
                end
            end
        endcase

        // write data follows its address into the data phase
        if (wr_accept) begin
            hwdata_n = wr_half;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            blk_cnt  <= '0;
            beat_cnt <= '0;
            hbusreq  <= 1'b0;
            htrans   <= HTRANS_IDLE;
            hwrite   <= 1'b0;
        end else begin
            state    <= state_n;
            blk_cnt  <= blk_cnt_n;
            beat_cnt <= beat_cnt_n;
            hbusreq  <= hbusreq_n;
            htrans   <= htrans_n;
            hwrite   <= hwrite_n;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_load) begin
            src_q <= src_addr_i;
            dst_q <= dst_addr_i;
            len_q <= len_i;
        end
        haddr  <= haddr_n;
        hwdata <= hwdata_n;
    end

    // ------------------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------------------
    assign idle_o       = (state == S_IDLE);

    assign hbusreq_o    = hbusreq;
    assign haddr_o      = haddr;
    assign htrans_o     = htrans;
    assign hwrite_o     = hwrite;
    assign hwdata_o     = hwdata;

    // entry for the write address currently on the bus
    assign buf_addr_o   = buf_addr_t'(beat_cnt[4:1]);

    assign beat_valid_o = beat_en;
    assign beat_idx_o   = beat_cnt[3:0];

endmodule

// ==== design/decomp_engine_top.sv ====
`timescale 1ns/1ps

module decomp_engine_top import decomp_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,

    // command
    input  logic [31:0]          src_addr_i,
    input  logic [31:0]          dst_addr_i,
    input  blk_cnt_t             len_i,
    input  logic                 start_i,
    output logic                 done_o,

    // AHB master, fixed 32-bit INCR16 data access
    output logic                 hbusreq_o,
    input  logic                 hgrant_i,
    output logic [31:0]          haddr_o,
    output htrans_t              htrans_o,
    output logic                 hwrite_o,
    output logic [31:0]          hwdata_o,
    input  logic                 hready_i,
    input  logic [31:0]          hrdata_i,

    // decompressor
    output logic [NUM_LANES-1:0] lane_wren_o,
    output logic                 decomp_sop_o,
    output logic                 decomp_eop_o,
    output logic [31:0]          decomp_wdata_o,
    input  logic                 decomp_done_i,
    output buf_addr_t            buf_addr_o,
    input  logic [63:0]          decomp_rdata_i
);

    logic       idle;
    logic       beat_valid;
    logic [3:0] beat_idx;

    // ------------------------------------------------------------------------
    // bus master and block loop
    // ------------------------------------------------------------------------
    ahb_block_master ahb_block_master_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .src_addr_i     (src_addr_i),
        .dst_addr_i     (dst_addr_i),
        .len_i          (len_i),
        .start_i        (start_i),
        .idle_o         (idle),
        .hbusreq_o      (hbusreq_o),
        .hgrant_i       (hgrant_i),
        .haddr_o        (haddr_o),
        .htrans_o       (htrans_o),
        .hwrite_o       (hwrite_o),
        .hwdata_o       (hwdata_o),
        .hready_i       (hready_i),
        .decomp_done_i  (decomp_done_i),
        .buf_addr_o     (buf_addr_o),
        .decomp_rdata_i (decomp_rdata_i),
        .beat_valid_o   (beat_valid),
        .beat_idx_o     (beat_idx)
    );

    // read words to the decompressor lanes
    decomp_lane_steer decomp_lane_steer_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .beat_valid_i   (beat_valid),
        .beat_idx_i     (beat_idx),
        .hrdata_i       (hrdata_i),
        .lane_wren_o    (lane_wren_o),
        .decomp_sop_o   (decomp_sop_o),
        .decomp_eop_o   (decomp_eop_o),
        .decomp_wdata_o (decomp_wdata_o)
    );

    // low already in the cycle of an accepted start, a zero length start is ignored
    assign done_o = idle && !(start_i && (len_i != '0));

endmodule

// ==== design/decomp_lane_steer.sv ====
`timescale 1ns/1ps

module decomp_lane_steer import decomp_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 beat_valid_i,
    input  logic [3:0]           beat_idx_i,
    input  logic [31:0]          hrdata_i,

    output logic [NUM_LANES-1:0] lane_wren_o,
    output logic                 decomp_sop_o,
    output logic                 decomp_eop_o,
    output logic [31:0]          decomp_wdata_o
);

    decomp_word_u         word_in;
    lane_t                owner, owner_n;
    logic                 first_beat;

    logic [NUM_LANES-1:0] lane_wren, lane_wren_n;
    logic                 sop_q;
    logic                 eop_q;
    logic [31:0]          wdata_q;

    assign word_in    = hrdata_i;
    assign first_beat = beat_valid_i && (beat_idx_i == 4'd0);

    // lane decided by the header in beat 0, kept for the rest of the block
    always_comb begin
        owner_n = owner;
        if (first_beat) begin
            if (word_in.hdr.direct) begin
                owner_n = LANE_DIRECT;
            end else if (!word_in.hdr.variant) begin
                owner_n = LANE_BASE;
            end else begin
                owner_n = LANE_VARIANT;
            end
        end

        for (int i = 0; i < NUM_LANES; i++) begin
            lane_wren_n[i] = beat_valid_i && (owner_n == lane_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner     <= LANE_DIRECT;
            lane_wren <= '0;
            sop_q     <= 1'b0;
            eop_q     <= 1'b0;
        end else begin
            owner     <= owner_n;
            lane_wren <= lane_wren_n;
            sop_q     <= first_beat;
            eop_q     <= beat_valid_i && (beat_idx_i == 4'(BEATS_PER_BURST - 1));
        end
    end

    // data word passed on untouched
    always_ff @(posedge clk) begin
        if (beat_valid_i) begin
            wdata_q <= word_in.raw;
        end
    end

    assign lane_wren_o    = lane_wren;
    assign decomp_sop_o   = sop_q;
    assign decomp_eop_o   = eop_q;
    assign decomp_wdata_o = wdata_q;

endmodule

// ==== design/decomp_pkg.sv ====
package decomp_pkg;

    // ------------------------------------------------------------------------
    // AHB transfer types
    // ------------------------------------------------------------------------
    typedef logic [1:0] htrans_t;

    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;
    localparam htrans_t HTRANS_SEQ    = 2'b11;

    // ------------------------------------------------------------------------
    // block geometry
    // ------------------------------------------------------------------------
    // every burst is INCR16 of 32-bit words
    localparam int unsigned BEATS_PER_BURST = 16;
    localparam logic [31:0] WORD_BYTES      = 32'd4;
    // 64-byte source block, 128-byte expanded destination block
    localparam int unsigned RD_BLK_SHIFT    = 6;
    localparam int unsigned WR_BLK_SHIFT    = 7;

    // counters and buffer indices
    typedef logic [25:0] blk_cnt_t;
    typedef logic [4:0]  beat_cnt_t;
    typedef logic [3:0]  buf_addr_t;

    // decompressor lanes
    localparam int unsigned NUM_LANES = 3;

    typedef logic [1:0] lane_t;

    localparam lane_t LANE_DIRECT  = 2'd0;
    localparam lane_t LANE_BASE    = 2'd1;
    localparam lane_t LANE_VARIANT = 2'd2;

    // first word of a block, either header or plain data
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic        direct;
            logic        variant;
            logic [29:0] payload;
        } hdr;
    } decomp_word_u;

endpackage

// ==== dv/decomp_engine_checker.sv ====
`timescale 1ns/1ps

module decomp_engine_checker import decomp_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 hbusreq_i,
    input  logic                 hgrant_i,
    input  logic [31:0]          haddr_i,
    input  htrans_t              htrans_i,
    input  logic                 hready_i,

    input  logic [NUM_LANES-1:0] lane_wren_i,
    input  logic                 sop_i,
    input  logic                 eop_i
);

    // --------------------------------------------------------------------------
    // lane side
    // --------------------------------------------------------------------------
    one_lane_per_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(lane_wren_i)
    ) else $error("more than one lane write enable in the same cycle");

    sop_eop_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(sop_i && eop_i)
    ) else $error("sop and eop high together");

    // --------------------------------------------------------------------------
    // bus side
    // --------------------------------------------------------------------------
    // a stalled address phase holds its transfer
    stall_holds_address: assert property (
        @(posedge clk) disable iff (!rst_n)
        (htrans_i != HTRANS_IDLE && !hready_i) |=> ($stable(htrans_i) && $stable(haddr_i))
    ) else $error("htrans or haddr moved while hready was low");

    request_drops_after_grant: assert property (
        @(posedge clk) disable iff (!rst_n)
        (hbusreq_i && hgrant_i) |=> !hbusreq_i
    ) else $error("hbusreq still high in the cycle after a grant");

endmodule

// ==== dv/decomp_engine_tb.sv ====
`timescale 1ns/1ps

module decomp_engine_tb import decomp_pkg::*; ();

    // 8 blocks over all tests at 200 cycles each plus reset and idle checks
    localparam int TOTAL_BLOCKS = 8;
    localparam int CYCLE_LIMIT  = TOTAL_BLOCKS * 200 + 500;

    logic                 clk;
    logic                 rst_n;
    logic [31:0]          src_addr;
    logic [31:0]          dst_addr;
    blk_cnt_t             len;
    logic                 start;
    logic                 done;
    logic                 hbusreq;
    logic                 hgrant;
    logic [31:0]          haddr;
    htrans_t              htrans;
    logic                 hwrite;
    logic [31:0]          hwdata;
    logic                 hready;
    logic [31:0]          hrdata;
    logic [NUM_LANES-1:0] lane_wren;
    logic                 sop;
    logic                 eop;
    logic [31:0]          dwdata;
    logic                 ddone;
    buf_addr_t            buf_addr;
    logic [63:0]          drdata;

    // slave memory with a fill pattern for words never written
    logic [31:0]          mem [logic [31:0]];
    logic                 dp_valid;
    logic                 dp_write;
    logic [31:0]          dp_addr;
    logic                 stress_en;
    logic [31:0]          lfsr;
    int                   cycle_cnt = 0;

    // completed bus transfers in order
    logic [31:0]          xfer_addr_q [$];
    logic                 xfer_write_q [$];
    logic [31:0]          xfer_data_q [$];
    // lane strobes seen by the decompressor
    lane_t                strb_lane_q [$];
    logic                 strb_sop_q [$];
    logic                 strb_eop_q [$];
    logic [31:0]          strb_data_q [$];

    int                   blk_seen;
    int                   buf_blk;
    int                   done_delay;
    lane_t                blk_lane [0:3];

    tb_clk_gen tb_clk_gen_i (
        .clk_o (clk)
    );

    decomp_engine_top decomp_engine_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .src_addr_i     (src_addr),
        .dst_addr_i     (dst_addr),
        .len_i          (len),
        .start_i        (start),
        .done_o         (done),
        .hbusreq_o      (hbusreq),
        .hgrant_i       (hgrant),
        .haddr_o        (haddr),
        .htrans_o       (htrans),
        .hwrite_o       (hwrite),
        .hwdata_o       (hwdata),
        .hready_i       (hready),
        .hrdata_i       (hrdata),
        .lane_wren_o    (lane_wren),
        .decomp_sop_o   (sop),
        .decomp_eop_o   (eop),
        .decomp_wdata_o (dwdata),
        .decomp_done_i  (ddone),
        .buf_addr_o     (buf_addr),
        .decomp_rdata_i (drdata)
    );

    bind decomp_engine_top decomp_engine_checker decomp_engine_checker_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .hbusreq_i   (hbusreq_o),
        .hgrant_i    (hgrant_i),
        .haddr_i     (haddr_o),
        .htrans_i    (htrans_o),
        .hready_i    (hready_i),
        .lane_wren_i (lane_wren_o),
        .sop_i       (decomp_sop_o),
        .eop_i       (decomp_eop_o)
    );

    // --------------------------------------------------------------------------
    // stimulus helpers
    // --------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit taken
    function automatic int unsigned rand_bits(int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | {31'b0, lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5c1e_93a7;
    endfunction

    function automatic logic [31:0] mem_read(logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return fill_word(addr);
    endfunction

    // expanded output for entry idx of block blk
    function automatic logic [63:0] buf_entry(int blk, int idx);
        return {8'hb7, 8'(blk), 12'h0f0, 4'(idx), 8'h4e, 8'(blk), 12'ha05, 4'(idx)};
    endfunction

    // header word whose class selects the given lane
    function automatic logic [31:0] header_for(lane_t lane, logic [29:0] payload);
        decomp_word_u w;
        w.hdr.payload = payload;
        w.hdr.direct  = (lane == 2'd0);
        w.hdr.variant = (lane == 2'd0) ? payload[0] : (lane == 2'd2);
        return w.raw;
    endfunction

    // --------------------------------------------------------------------------
    // compare tasks
    // --------------------------------------------------------------------------
    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_addr(logic [31:0] got, logic [31:0] exp, string what);
        if (got !== exp) begin
            $display("CHECK FAILED @ %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(logic [31:0] got, logic [31:0] exp, string what);
        if (got !== exp) begin
            $display("CHECK FAILED @ %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_trans(htrans_t got, htrans_t exp, string what);
        if (got !== exp) begin
            $display("CHECK FAILED @ %0t: %s got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_lane(lane_t got, lane_t exp, string what);
        if (got !== exp) begin
            $display("CHECK FAILED @ %0t: %s got lane %0d expected lane %0d",
                     $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(blk_cnt_t got, blk_cnt_t exp, string what);
        if (got !== exp) begin
            $display("CHECK FAILED @ %0t: %s got %0d expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("CHECK FAILED @ %0t: %s got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // --------------------------------------------------------------------------
    // AHB slave and arbiter model
    // --------------------------------------------------------------------------
    always @(negedge clk) begin
        logic rdy;
        if (!rst_n) begin
            hready   = 1'b1;
            hgrant   = 1'b0;
            hrdata   = '0;
            dp_valid = 1'b0;
        end else begin
            rdy = 1'b1;
            if (stress_en) begin
                rdy = (rand_bits(2) != 0);
            end
            // read data for the transfer in its data phase
            hrdata = (dp_valid && !dp_write) ? mem_read(dp_addr) : 32'h0;
            if (rdy) begin
                if (dp_valid) begin
                    xfer_addr_q.push_back(dp_addr);
                    xfer_write_q.push_back(dp_write);
                    xfer_data_q.push_back(dp_write ? hwdata : mem_read(dp_addr));
                end
                // a burst opens with NONSEQ and goes on with SEQ
                if (htrans != HTRANS_IDLE) begin
                    check_trans(htrans, dp_valid ? HTRANS_SEQ : HTRANS_NONSEQ,
                                "htrans of accepted address phase");
                end
                dp_valid = (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);
                dp_addr  = haddr;
                dp_write = hwrite;
            end
            hready = rdy;
            if (hbusreq) begin
                hgrant = stress_en ? (rand_bits(2) == 0) : 1'b1;
            end else begin
                hgrant = 1'b0;
            end
        end
    end

    // --------------------------------------------------------------------------
    // decompressor model
    // --------------------------------------------------------------------------
    always @(negedge clk) begin
        lane_t got_lane;
        if (!rst_n) begin
            ddone      = 1'b0;
            done_delay = 0;
            buf_blk    = 0;
        end else begin
            if (lane_wren != '0) begin
                got_lane = '0;
                for (int i = 0; i < NUM_LANES; i++) begin
                    if (lane_wren[i]) begin
                        got_lane = lane_t'(i);
                    end
                end
                strb_lane_q.push_back(got_lane);
                strb_sop_q.push_back(sop);
                strb_eop_q.push_back(eop);
                strb_data_q.push_back(dwdata);
            end
            if (eop) begin
                buf_blk    = blk_seen;
                blk_seen   = blk_seen + 1;
                done_delay = 3;
            end else if (done_delay > 0) begin
                done_delay = done_delay - 1;
                if (done_delay == 0) begin
                    ddone = 1'b1;
                end
            end
            // engine took the result once it asks for the bus again
            if (ddone && hbusreq) begin
                ddone = 1'b0;
            end
        end
        drdata = buf_entry(buf_blk, int'(buf_addr));
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("TIMEOUT: the engine did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    // --------------------------------------------------------------------------
    // run and verify
    // --------------------------------------------------------------------------
    task automatic write_block_header(logic [31:0] src, int b, lane_t lane);
        mem[src + 32'(b * 64)] = header_for(lane, 30'(rand_bits(30)));
        blk_lane[b] = lane;
    endtask

    task automatic clear_records();
        xfer_addr_q.delete();
        xfer_write_q.delete();
        xfer_data_q.delete();
        strb_lane_q.delete();
        strb_sop_q.delete();
        strb_eop_q.delete();
        strb_data_q.delete();
        blk_seen = 0;
    endtask

    task automatic pulse_start(logic [31:0] src, logic [31:0] dst, blk_cnt_t n);
        @(negedge clk);
        src_addr = src;
        dst_addr = dst;
        len      = n;
        start    = 1'b1;
        #1;
        check_flag(done, (n == '0), "done_o in the start cycle");
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic run_and_verify(logic [31:0] src, logic [31:0] dst, blk_cnt_t n);
        int          rises;
        int          high_cycles;
        logic        prev;
        int          idx;
        logic [31:0] rd_base;
        logic [63:0] entry;
        clear_records();
        pulse_start(src, dst, n);
        rises       = 0;
        high_cycles = 0;
        prev        = 1'b0;
        while (high_cycles < 6) begin
            @(negedge clk);
            if (done && !prev) begin
                rises++;
                check_count(blk_cnt_t'(xfer_addr_q.size()), blk_cnt_t'(n * 48),
                            "bus transfers when done_o rose");
            end
            prev = done;
            if (done) begin
                high_cycles++;
            end
        end
        check_count(blk_cnt_t'(rises), blk_cnt_t'(1), "done_o rising edges");
        check_flag(hbusreq, 1'b0, "hbusreq_o after completion");
        check_count(blk_cnt_t'(strb_lane_q.size()), blk_cnt_t'(n * 16), "lane strobes");

        for (int b = 0; b < int'(n); b++) begin
            rd_base = src + 32'(b * 64);
            for (int k = 0; k < 16; k++) begin
                idx = b * 48 + k;
                check_addr(xfer_addr_q[idx], rd_base + 32'(4 * k), "read address");
                check_flag(xfer_write_q[idx], 1'b0, "hwrite on read beat");
            end
            // 128 bytes out per block with the low half of the entry on even beats
            for (int k = 0; k < 32; k++) begin
                idx   = b * 48 + 16 + k;
                entry = buf_entry(b, k / 2);
                check_addr(xfer_addr_q[idx], dst + 32'(b * 128 + 4 * k), "write address");
                check_flag(xfer_write_q[idx], 1'b1, "hwrite on write beat");
                check_word(xfer_data_q[idx], (k % 2 == 1) ? entry[63:32] : entry[31:0],
                           "write data");
            end
            for (int j = 0; j < 16; j++) begin
                idx = b * 16 + j;
                check_lane(strb_lane_q[idx], blk_lane[b], "lane of strobe");
                check_flag(strb_sop_q[idx], (j == 0), "sop mark");
                check_flag(strb_eop_q[idx], (j == 15), "eop mark");
                check_word(strb_data_q[idx], mem_read(rd_base + 32'(4 * j)),
                           "decompressor data");
            end
        end
    endtask

    // --------------------------------------------------------------------------
    // directed tests
    // --------------------------------------------------------------------------
    task automatic test_single_block();
        write_block_header(32'h0000_1000, 0, LANE_DIRECT);
        run_and_verify(32'h0000_1000, 32'h0008_0000, blk_cnt_t'(1));
    endtask

    task automatic test_lane_select();
        logic [31:0] src;
        for (int l = 0; l < 3; l++) begin
            src = 32'h0000_2000 + 32'(l * 256);
            write_block_header(src, 0, lane_t'(l));
            run_and_verify(src, 32'h0008_4000 + 32'(l * 1024), blk_cnt_t'(1));
        end
    endtask

    task automatic test_backpressure();
        for (int b = 0; b < 3; b++) begin
            write_block_header(32'h0001_0000, b, lane_t'(rand_bits(2) % 3));
        end
        // random stalls and grant delays for this run only
        @(posedge clk);
        stress_en = 1'b1;
        run_and_verify(32'h0001_0000, 32'h0009_0000, blk_cnt_t'(3));
        @(posedge clk);
        stress_en = 1'b0;
    endtask

    task automatic test_zero_length();
        clear_records();
        pulse_start(32'h0000_4000, 32'h000a_0000, '0);
        repeat (20) begin
            @(negedge clk);
            check_flag(done, 1'b1, "done_o after zero length start");
            check_flag(hbusreq, 1'b0, "hbusreq_o after zero length start");
        end
        check_count(blk_cnt_t'(xfer_addr_q.size()), '0, "transfers after zero length start");
        write_block_header(32'h0000_4000, 0, LANE_BASE);
        run_and_verify(32'h0000_4000, 32'h000a_0000, blk_cnt_t'(1));
    endtask

    initial begin
        lfsr      = 32'h3f8b_a06b;
        rst_n     = 1'b0;
        start     = 1'b0;
        src_addr  = '0;
        dst_addr  = '0;
        len       = '0;
        stress_en = 1'b0;
        hgrant    = 1'b0;
        hready    = 1'b1;
        hrdata    = '0;
        ddone     = 1'b0;
        drdata    = '0;
        blk_seen  = 0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        test_single_block();
        test_lane_select();
        test_backpressure();
        test_zero_length();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o
);

    // 40 ns period, starts low
    initial begin
        clk_o = 1'b0;
    end

    always begin
        #20 clk_o = ~clk_o;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decompression engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -j 0 \
        -f sim.f --top-module decomp_engine_tb; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vdecomp_engine_tb)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q -F '*** PASSED ***'; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== sim.f ====
design/decomp_pkg.sv
design/ahb_block_master.sv
design/decomp_lane_steer.sv
design/decomp_engine_top.sv
dv/tb_clk_gen.sv
dv/decomp_engine_checker.sv
dv/decomp_engine_tb.sv
